// ==== dma_pkg.sv ====
package dma_pkg;

  // AHB transfer type.
  typedef enum logic [1:0] {
    TRANS_IDLE   = 2'b00,
    TRANS_BUSY   = 2'b01,
    TRANS_NONSEQ = 2'b10,
    TRANS_SEQ    = 2'b11
  } htrans_t;

  // AHB burst type, incrementing flavours only.
  typedef enum logic [2:0] {
    BURST_SINGLE = 3'b000,
    BURST_INCR   = 3'b001,
    BURST_INCR4  = 3'b011,
    BURST_INCR8  = 3'b101,
    BURST_INCR16 = 3'b111
  } hburst_t;

  // Beat counts of the fixed bursts, also the split thresholds.
  localparam int INCR4_BEATS  = 4;
  localparam int INCR8_BEATS  = 8;
  localparam int INCR16_BEATS = 16;

  // Length of a fixed burst, zero for undefined length.
  function automatic logic [4:0] burst_beats(input hburst_t burst);
    case (burst)
      BURST_SINGLE: burst_beats = 5'd1;
      BURST_INCR4:  burst_beats = 5'(INCR4_BEATS);
      BURST_INCR8:  burst_beats = 5'(INCR8_BEATS);
      BURST_INCR16: burst_beats = 5'(INCR16_BEATS);
      default:      burst_beats = 5'd0;
    endcase
  endfunction

endpackage

// ==== cmd_dispatch.sv ====
`timescale 1ns/1ps

module cmd_dispatch #(
  parameter int NUM_CH    = 4,
  parameter int ADDRW     = 32,
  parameter int BYTE_CNTW = 16,
  localparam int CHW      = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cmd_req,
  input  logic [CHW-1:0]                    cmd_ch,
  input  logic [ADDRW-1:0]                  cmd_addr,
  input  logic [BYTE_CNTW-1:0]              cmd_byte_cnt,
  input  logic                              cmd_wr,
  output logic                              cmd_ack,
  output logic [NUM_CH-1:0]                 ch_req,
  output logic [NUM_CH-1:0][ADDRW-1:0]      ch_addr,
  output logic [NUM_CH-1:0][BYTE_CNTW-1:0]  ch_byte_cnt,
  output logic [NUM_CH-1:0]                 ch_wr,
  input  logic [NUM_CH-1:0]                 ch_ack
);

  logic [NUM_CH-1:0] slot_full;
  logic              take;

  // Back-pressure per addressed channel.
  assign cmd_ack = ~slot_full[cmd_ch];
  assign take    = cmd_req & cmd_ack;
  assign ch_req  = slot_full;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      slot_full <= '0;
    end else begin
      for (int i = 0; i < NUM_CH; i++) begin
        if (ch_ack[i]) begin
          slot_full[i] <= 1'b0; // Master has taken it.
        end else if (take && cmd_ch == CHW'(i)) begin
          slot_full[i] <= 1'b1;
        end
      end
    end
  end

  // Command payload of each slot.
  always_ff @(posedge clk) begin
    if (take) begin
      ch_addr[cmd_ch]     <= cmd_addr;
      ch_byte_cnt[cmd_ch] <= cmd_byte_cnt;
      ch_wr[cmd_ch]       <= cmd_wr;
    end
  end

endmodule

// ==== ahb_burst_master.sv ====
`timescale 1ns/1ps

module ahb_burst_master #(
  parameter int ADDRW     = 32,
  parameter int DATAW     = 64,
  parameter int BYTE_CNTW = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  logic [ADDRW-1:0]     start_addr,
  input  logic [BYTE_CNTW-1:0] byte_cnt,
  input  logic                 wr,
  output logic                 ack,
  output logic                 done,
  input  logic                 hgrant,
  input  logic                 hready,
  output logic [ADDRW-1:0]     haddr,
  output dma_pkg::htrans_t     htrans,
  output dma_pkg::hburst_t     hburst,
  output logic [2:0]           hsize,
  output logic                 hwrite
);

  import dma_pkg::*;

  localparam int BB    = DATAW / 8;
  localparam int BB_LG = $clog2(BB);

  localparam logic [1:0] IDLE    = 2'd0;
  localparam logic [1:0] START   = 2'd1;
  localparam logic [1:0] FX_INCR = 2'd2;
  localparam logic [1:0] UN_INCR = 2'd3;

  logic [1:0]           state;
  logic [BYTE_CNTW-1:0] rem_bytes;
  logic [BYTE_CNTW-1:0] rem_un_nxt;
  logic [4:0]           beat_cnt;
  logic [4:0]           burst_len;
  logic                 pend_done;

  logic                 adv;
  logic                 burst_end;
  logic                 cmd_end;
  logic                 do_load;
  logic                 do_step;
  logic                 do_stop;

  logic [ADDRW-1:0]     ld_addr;
  logic [BYTE_CNTW-1:0] ld_bytes;
  logic                 ld_wr;
  logic [BYTE_CNTW:0]   ld_beats;
  logic [4:0]           ld_len;
  hburst_t              ld_burst;
  logic [BYTE_CNTW:0]   ld_take;
  logic [BYTE_CNTW-1:0] ld_rem;

  assign hsize = 3'(BB_LG);

  // Address phase accepted only for the owner.
  assign adv = hgrant & hready;

  always_comb begin
    burst_end = 1'b0;
    if (adv) begin
      if (state == FX_INCR) begin
        burst_end = (beat_cnt == burst_len);
      end else if (state == UN_INCR) begin
        burst_end = (rem_bytes == '0);
      end
    end
    cmd_end = burst_end && (state == UN_INCR || rem_bytes == '0);
    ack     = (state == START) || (cmd_end && req);
    do_load = ack || (burst_end && !cmd_end);
    do_step = adv && (state == FX_INCR || state == UN_INCR) && !burst_end;
    do_stop = cmd_end && !req;
  end

  // Source of the next burst: a new command or the rest of this one.
  always_comb begin
    if (ack) begin
      ld_addr  = start_addr;
      ld_bytes = byte_cnt;
      ld_wr    = wr;
    end else begin
      ld_addr  = haddr + ADDRW'(BB);
      ld_bytes = rem_bytes;
      ld_wr    = hwrite;
    end
    ld_beats = (BYTE_CNTW+1)'((32'(ld_bytes) + BB - 1) >> BB_LG); // Rounded up.
    if (ld_beats >= INCR16_BEATS) begin
      ld_burst = BURST_INCR16;
      ld_len   = 5'(INCR16_BEATS);
    end else if (ld_beats >= INCR8_BEATS) begin
      ld_burst = BURST_INCR8;
      ld_len   = 5'(INCR8_BEATS);
    end else if (ld_beats >= INCR4_BEATS) begin
      ld_burst = BURST_INCR4;
      ld_len   = 5'(INCR4_BEATS);
    end else begin
      ld_burst = BURST_INCR; // Short tail of 1 to 3 beats.
      ld_len   = 5'(ld_beats);
    end
    // Tail counts down per beat, fixed bursts per burst.
    ld_take = (ld_burst == BURST_INCR) ? (BYTE_CNTW+1)'(BB) : (BYTE_CNTW+1)'(ld_len * BB);
    ld_rem  = ({1'b0, ld_bytes} > ld_take) ? BYTE_CNTW'({1'b0, ld_bytes} - ld_take) : '0;
  end

  assign rem_un_nxt = (rem_bytes > BYTE_CNTW'(BB)) ? rem_bytes - BYTE_CNTW'(BB) : '0;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= IDLE;
      haddr     <= '0;
      htrans    <= TRANS_IDLE;
      hburst    <= BURST_SINGLE;
      hwrite    <= 1'b0;
      rem_bytes <= '0;
      beat_cnt  <= '0;
      burst_len <= '0;
      pend_done <= 1'b0;
    end else begin
      pend_done <= cmd_end | (pend_done & ~hready);
      if (do_load) begin
        state     <= (ld_burst == BURST_INCR) ? UN_INCR : FX_INCR;
        haddr     <= ld_addr;
        htrans    <= TRANS_NONSEQ;
        hburst    <= ld_burst;
        hwrite    <= ld_wr;
        rem_bytes <= ld_rem;
        beat_cnt  <= 5'd1;
        burst_len <= ld_len;
      end else if (do_step) begin
        haddr    <= haddr + ADDRW'(BB);
        htrans   <= TRANS_SEQ;
        beat_cnt <= beat_cnt + 5'd1;
        if (state == UN_INCR) begin
          rem_bytes <= rem_un_nxt;
        end
      end else if (do_stop) begin
        state  <= IDLE;
        htrans <= TRANS_IDLE;
      end else if (state == IDLE && req) begin
        state <= START;
      end
    end
  end

  // Last data phase of the command completes.
  assign done = pend_done & hready;

endmodule

// ==== ahb_arbiter.sv ====
`timescale 1ns/1ps

module ahb_arbiter #(
  parameter int NUM_CH = 4,
  parameter int ADDRW  = 32,
  parameter int DATAW  = 64,
  localparam int CHW   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [NUM_CH-1:0][ADDRW-1:0] m_haddr,
  input  dma_pkg::htrans_t [NUM_CH-1:0] m_htrans,
  input  dma_pkg::hburst_t [NUM_CH-1:0] m_hburst,
  input  logic [NUM_CH-1:0][2:0]       m_hsize,
  input  logic [NUM_CH-1:0]            m_hwrite,
  output logic [NUM_CH-1:0]            hgrant,
  output logic [NUM_CH-1:0]            hready_m,
  output logic [ADDRW-1:0]             haddr,
  output dma_pkg::htrans_t             htrans,
  output dma_pkg::hburst_t             hburst,
  output logic [2:0]                   hsize,
  output logic                         hwrite,
  input  logic                         hready,
  input  logic [DATAW-1:0]             hrdata,
  output logic [NUM_CH-1:0]            wdata_pull,
  output logic                         rdata_valid,
  output logic [CHW-1:0]               rdata_ch,
  output logic [DATAW-1:0]             rdata,
  output logic [CHW-1:0]               dphase_ch
);

  import dma_pkg::*;

  logic [CHW-1:0] owner;
  logic           owner_vld;
  logic [CHW-1:0] nxt_owner;
  logic           nxt_found;
  logic [4:0]     beat_cnt;
  logic [4:0]     this_beat;
  logic [4:0]     fixed_len;
  logic           active;
  logic           last_fixed;
  logic           handover;
  logic           dphase_vld;
  logic           dphase_wr;

  // Address phase mux.
  assign haddr  = m_haddr[owner];
  assign htrans = owner_vld ? m_htrans[owner] : TRANS_IDLE;
  assign hburst = m_hburst[owner];
  assign hsize  = m_hsize[owner];
  assign hwrite = m_hwrite[owner];

  assign active     = (htrans == TRANS_NONSEQ) || (htrans == TRANS_SEQ);
  assign this_beat  = (htrans == TRANS_NONSEQ) ? 5'd1 : beat_cnt + 5'd1;
  assign fixed_len  = burst_beats(hburst);
  assign last_fixed = hready && active && fixed_len != '0 && this_beat == fixed_len;

  // Owner may only move on a burst boundary.
  assign handover = hready && (!owner_vld || htrans == TRANS_IDLE || last_fixed);

  // Round-robin search starting after the current owner.
  always_comb begin
    int idx;
    nxt_owner = owner;
    nxt_found = 1'b0;
    for (int k = 1; k <= NUM_CH; k++) begin
      idx = (int'(owner) + k) % NUM_CH;
      if (!nxt_found && m_htrans[idx] != TRANS_IDLE) begin
        nxt_owner = CHW'(idx);
        nxt_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      owner      <= '0;
      owner_vld  <= 1'b0;
      beat_cnt   <= '0;
      dphase_vld <= 1'b0;
      dphase_wr  <= 1'b0;
      dphase_ch  <= '0;
    end else begin
      if (handover) begin
        owner     <= nxt_owner;
        owner_vld <= nxt_found;
      end
      if (hready) begin
        dphase_vld <= active; // Data phase trails address by one.
        dphase_wr  <= hwrite;
        dphase_ch  <= owner;
        if (active) begin
          beat_cnt <= this_beat;
        end
      end
    end
  end

  // Hready reaches the address owner and the data-phase owner.
  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      hgrant[i]     = owner_vld && owner == CHW'(i);
      hready_m[i]   = hready && (hgrant[i] || (dphase_vld && dphase_ch == CHW'(i)));
      wdata_pull[i] = hready && dphase_vld && dphase_wr && dphase_ch == CHW'(i);
    end
  end

  assign rdata_valid = hready & dphase_vld & ~dphase_wr;
  assign rdata_ch    = dphase_ch;
  assign rdata       = hrdata;

endmodule

// ==== dma_ahb_top.sv ====
`timescale 1ns/1ps

module dma_ahb_top #(
  parameter int NUM_CH    = 4,
  parameter int ADDRW     = 32,
  parameter int DATAW     = 64,
  parameter int BYTE_CNTW = 16,
  localparam int CHW      = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         cmd_req,
  input  logic [CHW-1:0]               cmd_ch,
  input  logic [ADDRW-1:0]             cmd_addr,
  input  logic [BYTE_CNTW-1:0]         cmd_byte_cnt,
  input  logic                         cmd_wr,
  output logic                         cmd_ack,
  output logic [NUM_CH-1:0]            cmd_done,
  input  logic [NUM_CH-1:0][DATAW-1:0] wdata,
  output logic [NUM_CH-1:0]            wdata_pull,
  output logic [ADDRW-1:0]             haddr,
  output dma_pkg::htrans_t             htrans,
  output dma_pkg::hburst_t             hburst,
  output logic [2:0]                   hsize,
  output logic                         hwrite,
  output logic [DATAW-1:0]             hwdata,
  output logic [3:0]                   hprot,
  output logic                         hmastlock,
  input  logic                         hready,
  input  logic [DATAW-1:0]             hrdata,
  output logic                         rdata_valid,
  output logic [CHW-1:0]               rdata_ch,
  output logic [DATAW-1:0]             rdata
);

  import dma_pkg::*;

  logic [NUM_CH-1:0]                ch_req;
  logic [NUM_CH-1:0][ADDRW-1:0]     ch_addr;
  logic [NUM_CH-1:0][BYTE_CNTW-1:0] ch_byte_cnt;
  logic [NUM_CH-1:0]                ch_wr;
  logic [NUM_CH-1:0]                ch_ack;

  logic [NUM_CH-1:0][ADDRW-1:0]     m_haddr;
  htrans_t [NUM_CH-1:0]             m_htrans;
  hburst_t [NUM_CH-1:0]             m_hburst;
  logic [NUM_CH-1:0][2:0]           m_hsize;
  logic [NUM_CH-1:0]                m_hwrite;
  logic [NUM_CH-1:0]                hgrant;
  logic [NUM_CH-1:0]                hready_m;
  logic [CHW-1:0]                   dphase_ch;

  assign hprot     = 4'b0000;
  assign hmastlock = 1'b0;
  assign hwdata    = wdata[dphase_ch]; // Data-phase owner's slice.

  cmd_dispatch #(
    .NUM_CH    (NUM_CH),
    .ADDRW     (ADDRW),
    .BYTE_CNTW (BYTE_CNTW)
  ) u_dispatch (
    .clk          (clk),
    .rst          (rst),
    .cmd_req      (cmd_req),
    .cmd_ch       (cmd_ch),
    .cmd_addr     (cmd_addr),
    .cmd_byte_cnt (cmd_byte_cnt),
    .cmd_wr       (cmd_wr),
    .cmd_ack      (cmd_ack),
    .ch_req       (ch_req),
    .ch_addr      (ch_addr),
    .ch_byte_cnt  (ch_byte_cnt),
    .ch_wr        (ch_wr),
    .ch_ack       (ch_ack)
  );

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    ahb_burst_master #(
      .ADDRW     (ADDRW),
      .DATAW     (DATAW),
      .BYTE_CNTW (BYTE_CNTW)
    ) u_master (
      .clk        (clk),
      .rst        (rst),
      .req        (ch_req[i]),
      .start_addr (ch_addr[i]),
      .byte_cnt   (ch_byte_cnt[i]),
      .wr         (ch_wr[i]),
      .ack        (ch_ack[i]),
      .done       (cmd_done[i]),
      .hgrant     (hgrant[i]),
      .hready     (hready_m[i]),
      .haddr      (m_haddr[i]),
      .htrans     (m_htrans[i]),
      .hburst     (m_hburst[i]),
      .hsize      (m_hsize[i]),
      .hwrite     (m_hwrite[i])
    );
  end

  ahb_arbiter #(
    .NUM_CH (NUM_CH),
    .ADDRW  (ADDRW),
    .DATAW  (DATAW)
  ) u_arbiter (
    .clk         (clk),
    .rst         (rst),
    .m_haddr     (m_haddr),
    .m_htrans    (m_htrans),
    .m_hburst    (m_hburst),
    .m_hsize     (m_hsize),
    .m_hwrite    (m_hwrite),
    .hgrant      (hgrant),
    .hready_m    (hready_m),
    .haddr       (haddr),
    .htrans      (htrans),
    .hburst      (hburst),
    .hsize       (hsize),
    .hwrite      (hwrite),
    .hready      (hready),
    .hrdata      (hrdata),
    .wdata_pull  (wdata_pull),
    .rdata_valid (rdata_valid),
    .rdata_ch    (rdata_ch),
    .rdata       (rdata),
    .dphase_ch   (dphase_ch)
  );

endmodule

// ==== dma_ahb_properties.sv ====
`timescale 1ns/1ps

module dma_ahb_properties #(
  parameter int NUM_CH = 4,
  parameter int ADDRW  = 32
) (
  input logic              clk,
  input logic              rst,
  input logic              hready,
  input dma_pkg::htrans_t  htrans,
  input logic [ADDRW-1:0]  haddr,
  input dma_pkg::hburst_t  hburst,
  input logic [2:0]        hsize,
  input logic              hwrite,
  input logic [NUM_CH-1:0] hgrant
);

  import dma_pkg::*;

  int unsigned fail_cnt = 0;
  logic [4:0]  beat_no;
  logic [4:0]  cur_beat;
  logic [4:0]  fixed_len;
  logic        active;
  logic        mid_burst;

  assign active    = (htrans == TRANS_NONSEQ) || (htrans == TRANS_SEQ);
  assign cur_beat  = (htrans == TRANS_NONSEQ) ? 5'd1 : beat_no + 5'd1;
  assign mid_burst = hready && active && fixed_len != '0 && cur_beat < fixed_len;

  always_comb begin
    case (hburst)
      BURST_INCR16: fixed_len = 5'(INCR16_BEATS);
      BURST_INCR8:  fixed_len = 5'(INCR8_BEATS);
      BURST_INCR4:  fixed_len = 5'(INCR4_BEATS);
      default:      fixed_len = 5'd0; // Undefined length.
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      beat_no <= '0;
    end else if (hready && active) begin
      beat_no <= cur_beat;
    end
  end

  a_hold: assert property (@(posedge clk) disable iff (!rst)
    (!hready && active) |=> $stable({haddr, htrans, hburst, hsize, hwrite}))
    else begin
      $error("address or control changed during a wait state");
      fail_cnt++;
    end

  // Grant moves only after a cycle with hready high.
  a_grant: assert property (@(posedge clk) disable iff (!rst)
    $onehot0(hgrant) && ($past(hready) || $stable(hgrant)))
    else begin
      $error("grant not one-hot or moved during a wait state");
      fail_cnt++;
    end

  a_owner: assert property (@(posedge clk) disable iff (!rst)
    mid_burst |=> hgrant == $past(hgrant))
    else begin
      $error("bus owner changed inside a fixed burst");
      fail_cnt++;
    end

endmodule

// ==== dma_ahb_tb.sv ====
`timescale 1ns/1ps

module dma_ahb_tb;

  import dma_pkg::*;

  localparam int NUM_CH = 4;
  localparam int DATAW  = 64;
  localparam int BB     = DATAW / 8;
  localparam int NWR    = 5; // Write commands per channel.
  localparam int DRV    = 2;

  typedef struct packed {
    hburst_t     kind;
    logic [31:0] addr;
    logic [4:0]  beats;
  } burst_t;

  typedef struct packed {
    logic [31:0] addr;
    hburst_t     kind;
    logic        first;
    logic        wr;
  } beat_t;

  typedef struct packed {
    logic [1:0]  ch;
    logic [31:0] addr;
    logic [15:0] bytes;
    logic        wr;
  } cmd_t;

  logic                         clk;
  logic                         rst;
  logic                         cmd_req;
  logic [1:0]                   cmd_ch;
  logic [31:0]                  cmd_addr;
  logic [15:0]                  cmd_byte_cnt;
  logic                         cmd_wr;
  logic                         cmd_ack;
  logic [NUM_CH-1:0]            cmd_done;
  logic [NUM_CH-1:0][DATAW-1:0] wdata;
  logic [NUM_CH-1:0]            wdata_pull;
  logic [31:0]                  haddr;
  htrans_t                      htrans;
  hburst_t                      hburst;
  logic [2:0]                   hsize;
  logic                         hwrite;
  logic [DATAW-1:0]             hwdata;
  logic [3:0]                   hprot;
  logic                         hmastlock;
  logic                         hready;
  logic [DATAW-1:0]             hrdata;
  logic                         rdata_valid;
  logic [1:0]                   rdata_ch;
  logic [DATAW-1:0]             rdata;

  cmd_t             cmds[$];
  beat_t            exp_beats[NUM_CH][$];
  logic [DATAW-1:0] exp_rdata[NUM_CH][$];
  logic [DATAW-1:0] exp_mem[logic [31:0]];
  logic [DATAW-1:0] mem[logic [31:0]]; // Sparse slave memory.
  int               sizes[8] = '{128, 64, 32, 20, 248, 100, 16, 8};
  int               wr_beats[NUM_CH];
  int               wcnt[NUM_CH];
  int               done_cnt[NUM_CH];
  int               cmd_cnt[NUM_CH];
  int               done_total = 0;
  int               errors = 0;
  int               beats_seen = 0;
  int               total_beats = 0;
  int               cycles = 0;
  int               limit = 100000;
  int               seed = 14;
  int               burst_left = 0;
  logic [1:0]       burst_ch;
  logic             dp_vld = 1'b0;
  logic             dp_wr = 1'b0;
  logic [31:0]      dp_addr = '0;

  dma_ahb_top #(.NUM_CH(NUM_CH), .ADDRW(32), .DATAW(DATAW), .BYTE_CNTW(16)) dut0 (.*);

  bind ahb_arbiter dma_ahb_properties #(.NUM_CH(NUM_CH), .ADDRW(ADDRW)) u_props (
    .clk    (clk),
    .rst    (rst),
    .hready (hready),
    .htrans (htrans),
    .haddr  (haddr),
    .hburst (hburst),
    .hsize  (hsize),
    .hwrite (hwrite),
    .hgrant (hgrant)
  );

  function automatic logic [63:0] wpat(input int ch, input int k);
    return {16'hD0A0 + 16'(ch), 16'(k), (32'(k) * 32'h9E37_79B9) ^ 32'(ch)};
  endfunction

  function automatic logic [63:0] fill_word(input logic [31:0] a);
    return {~a, a ^ 32'h5A5A_A5A5};
  endfunction

  function automatic logic [63:0] read_word(input logic [31:0] a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  // Expected burst list of one command.
  function automatic void ref_bursts(input logic [31:0] start, input int bytes,
                                     output burst_t list[$]);
    int     beats;
    int     n;
    burst_t b;
    list  = {};
    beats = (bytes + BB - 1) / BB;
    while (beats > 0) begin
      if (beats >= 16) n = 16;
      else if (beats >= 8) n = 8;
      else if (beats >= 4) n = 4;
      else n = beats; // Tail as one INCR.
      case (n)
        16:      b.kind = BURST_INCR16;
        8:       b.kind = BURST_INCR8;
        4:       b.kind = BURST_INCR4;
        default: b.kind = BURST_INCR;
      endcase
      b.addr  = start;
      b.beats = 5'(n);
      list.push_back(b);
      start = start + 32'(n * BB);
      beats = beats - n;
    end
  endfunction

  task automatic queue_cmd(input int ch, input int j, input logic wr);
    burst_t      list[$];
    beat_t       e;
    logic [31:0] a;
    cmd_t        c;
    c = '{ch: 2'(ch), addr: 32'h0001_0000 + 32'(ch << 12) + 32'(j * 256),
          bytes: 16'(sizes[(ch + j) % 8]), wr: wr};
    ref_bursts(c.addr, int'(c.bytes), list);
    foreach (list[b]) begin
      for (int k = 0; k < int'(list[b].beats); k++) begin
        a       = list[b].addr + 32'(k * BB);
        e.addr  = a;
        e.kind  = list[b].kind;
        e.first = (k == 0);
        e.wr    = wr;
        exp_beats[ch].push_back(e);
        if (wr) begin
          exp_mem[a] = wpat(ch, wr_beats[ch]);
          wr_beats[ch]++;
        end else begin
          exp_rdata[ch].push_back(exp_mem.exists(a) ? exp_mem[a] : fill_word(a));
        end
        total_beats++;
      end
    end
    cmds.push_back(c);
    cmd_cnt[ch]++;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
    $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp_v, got_v);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // AHB slave with random wait states, and the write data source.
  always @(posedge clk) begin
    if (!rst) begin
      dp_vld = 1'b0;
    end else begin
      if (hready) begin
        if (dp_vld && dp_wr) mem[dp_addr] = hwdata;
        dp_vld  = (htrans == TRANS_NONSEQ) || (htrans == TRANS_SEQ);
        dp_addr = haddr;
        dp_wr   = hwrite;
      end
      for (int i = 0; i < NUM_CH; i++) begin
        if (wdata_pull[i]) wcnt[i]++;
      end
    end
    #DRV;
    hready = dp_vld ? (($random(seed) & 3) != 0) : 1'b1;
    hrdata = (dp_vld && !dp_wr) ? read_word(dp_addr) : '0;
    for (int i = 0; i < NUM_CH; i++) begin
      wdata[i] = wpat(i, wcnt[i]);
    end
  end

  // Bus, read data and completion checker.
  always @(posedge clk) begin : check_bus
    logic [1:0]       ch;
    beat_t            e;
    logic [DATAW-1:0] ev;
    int               len;
    if (rst && hready && (htrans == TRANS_NONSEQ || htrans == TRANS_SEQ)) begin
      ch = haddr[13:12]; // Channel region.
      beats_seen++;
      if (burst_left > 0 && (htrans == TRANS_NONSEQ || ch != burst_ch)) begin
        report_error("fixed burst interleaved with another transfer");
      end
      if (htrans == TRANS_NONSEQ) begin
        case (hburst)
          BURST_INCR16: len = 16;
          BURST_INCR8:  len = 8;
          BURST_INCR4:  len = 4;
          default:      len = 0;
        endcase
        burst_left = (len > 0) ? len - 1 : 0;
        burst_ch   = ch;
      end else if (burst_left > 0) begin
        burst_left--;
      end
      if (exp_beats[ch].size() == 0) begin
        report_error($sformatf("unexpected beat at address %h", haddr));
      end else begin
        e = exp_beats[ch].pop_front();
        if (haddr != e.addr) report_mismatch("haddr", e.addr, haddr);
        if (hburst != e.kind) report_mismatch("hburst", e.kind, hburst);
        if ((htrans == TRANS_NONSEQ) != e.first) begin
          report_mismatch("htrans", e.first ? TRANS_NONSEQ : TRANS_SEQ, htrans);
        end
        if (hwrite != e.wr) report_mismatch("hwrite", e.wr, hwrite);
        if (hsize != 3'd3) report_mismatch("hsize", 3'd3, hsize);
      end
      if (hprot !== 4'b0000) report_mismatch("hprot", 4'b0000, hprot);
      if (hmastlock !== 1'b0) report_mismatch("hmastlock", 1'b0, hmastlock);
    end
    if (rst && rdata_valid) begin
      if (exp_rdata[rdata_ch].size() == 0) begin
        report_error($sformatf("unexpected read data on channel %0d", rdata_ch));
      end else begin
        ev = exp_rdata[rdata_ch].pop_front();
        if (rdata != ev) report_mismatch($sformatf("rdata ch%0d", rdata_ch), ev, rdata);
      end
    end
    for (int i = 0; i < NUM_CH; i++) begin
      if (rst && cmd_done[i]) begin
        done_cnt[i]++;
        done_total++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      report_error("timeout before all commands completed");
      $display("Errors: %0d, beats checked: %0d", errors, beats_seen);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    rst          = 1'b0;
    cmd_req      = 1'b0;
    cmd_ch       = '0;
    cmd_addr     = '0;
    cmd_byte_cnt = '0;
    cmd_wr       = 1'b0;
    hready       = 1'b1;
    hrdata       = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      wdata[i] = wpat(i, 0);
    end
    // Writes spread over channels, then read-back grouped per channel.
    for (int j = 0; j < NWR; j++) begin
      for (int i = 0; i < NUM_CH; i++) queue_cmd(i, j, 1'b1);
    end
    for (int i = 0; i < NUM_CH; i++) begin
      for (int j = 0; j < NWR; j++) queue_cmd(i, j, 1'b0);
    end
    limit = 4 * total_beats + 2000;
    repeat (16) @(posedge clk);
    if (cmd_ack !== 1'b1) report_mismatch("cmd_ack", 1'b1, cmd_ack);
    if (htrans !== TRANS_IDLE) report_mismatch("htrans", TRANS_IDLE, htrans);
    if (cmd_done !== '0) report_mismatch("cmd_done", '0, cmd_done);
    if (wdata_pull !== '0) report_mismatch("wdata_pull", '0, wdata_pull);
    if (rdata_valid !== 1'b0) report_mismatch("rdata_valid", 1'b0, rdata_valid);
    if (hprot !== 4'b0000) report_mismatch("hprot", 4'b0000, hprot);
    if (hmastlock !== 1'b0) report_mismatch("hmastlock", 1'b0, hmastlock);
    #DRV rst = 1'b1;
    @(posedge clk);
    #DRV;
    for (int n = 0; n < cmds.size(); n++) begin
      cmd_req      = 1'b1;
      cmd_ch       = cmds[n].ch;
      cmd_addr     = cmds[n].addr;
      cmd_byte_cnt = cmds[n].bytes;
      cmd_wr       = cmds[n].wr;
      @(posedge clk);
      if (n > 0 && cmds[n].ch == cmds[n-1].ch && cmd_ack) begin
        report_error("cmd_ack high while the channel slot is full");
      end
      while (!cmd_ack) @(posedge clk);
      #DRV;
    end
    cmd_req = 1'b0;
    while (done_total < cmds.size()) @(posedge clk);
    repeat (20) @(posedge clk); // Catch stray done pulses.
    for (int i = 0; i < NUM_CH; i++) begin
      if (done_cnt[i] != cmd_cnt[i]) begin
        report_mismatch($sformatf("cmd_done[%0d] count", i), cmd_cnt[i], done_cnt[i]);
      end
      if (exp_beats[i].size() != 0) report_error($sformatf("beats missing on ch%0d", i));
      if (exp_rdata[i].size() != 0) report_error($sformatf("read data missing on ch%0d", i));
    end
    foreach (exp_mem[a]) begin
      if (!mem.exists(a)) report_error($sformatf("address %h never written", a));
      else if (mem[a] != exp_mem[a]) report_mismatch($sformatf("mem[%h]", a), exp_mem[a], mem[a]);
    end
    errors = errors + int'(dut0.u_arbiter.u_props.fail_cnt);
    $display("Errors: %0d, beats checked: %0d", errors, beats_seen);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== dma_ahb.f ====
dma_pkg.sv
cmd_dispatch.sv
ahb_burst_master.sv
ahb_arbiter.sv
dma_ahb_top.sv
dma_ahb_properties.sv
dma_ahb_tb.sv

// ==== Bender.yml ====
package:
  name: dma_ahb

sources:
  - dma_pkg.sv
  - cmd_dispatch.sv
  - ahb_burst_master.sv
  - ahb_arbiter.sv
  - dma_ahb_top.sv
  - target: test
    files:
      - dma_ahb_properties.sv
      - dma_ahb_tb.sv
